/* source/configure.sv */
package configure;

  // address map seen by the bus master, each region is [base, top)
  localparam logic [31 : 0] bram_base_addr = 32'h0000_0000;
  localparam logic [31 : 0] bram_top_addr = 32'h0000_1000;

  localparam logic [31 : 0] clint_base_addr = 32'h0200_0000;
  localparam logic [31 : 0] clint_top_addr = 32'h0200_C000;

  localparam logic [31 : 0] uart_base_addr = 32'h1000_0000;
  localparam logic [31 : 0] uart_top_addr = 32'h1000_0008;

  // CLINT register offsets relative to clint_base_addr
  localparam logic [31 : 0] clint_msip_offset = 32'h0000_0000;
  localparam logic [31 : 0] clint_mtimecmp_offset = 32'h0000_4000; // high word at +4
  localparam logic [31 : 0] clint_mtime_offset = 32'h0000_BFF8; // high word at +4

  // UART register offsets relative to uart_base_addr
  localparam logic [31 : 0] uart_data_offset = 32'h0000_0000;
  localparam logic [31 : 0] uart_status_offset = 32'h0000_0004;

endpackage

/* source/bus_types.sv */
package bus_types;

  // one request from the master, held stable while valid is high
  typedef struct packed {
    logic valid;
    logic instr; // set for instruction fetches
    logic [31 : 0] addr;
    logic [31 : 0] wdata;
    logic [3 : 0] wstrb; // any bit set makes the access a write
  } mem_req_t;

  // the answer, ready is high for a single cycle
  typedef struct packed {
    logic [31 : 0] rdata;
    logic ready;
  } mem_rsp_t;

endpackage

/* source/bus_decoder.sv */
`timescale 1ns/10ps

module bus_decoder
(
  input  logic clk,
  input  logic reset,
  input  bus_types::mem_req_t req,
  output bus_types::mem_rsp_t rsp,
  output bus_types::mem_req_t bram_req,
  output bus_types::mem_req_t clint_req,
  output bus_types::mem_req_t uart_req,
  input  bus_types::mem_rsp_t bram_rsp,
  input  bus_types::mem_rsp_t clint_rsp,
  input  bus_types::mem_rsp_t uart_rsp
);
  import configure::*;

  logic bram_sel;
  logic clint_sel;
  logic uart_sel;
  logic unmapped_sel;
  logic [31 : 0] base_addr;
  logic [31 : 0] offset_addr;
  logic unmapped_ready;

  function automatic logic in_region(input logic [31 : 0] addr, input logic [31 : 0] base,
                                     input logic [31 : 0] top);
    return (addr >= base) && (addr < top);
  endfunction

  always_comb begin
    bram_sel = 1'b0;
    clint_sel = 1'b0;
    uart_sel = 1'b0;
    unmapped_sel = 1'b0;
    base_addr = '0;
    if (in_region(req.addr, bram_base_addr, bram_top_addr)) begin
      bram_sel = 1'b1;
      base_addr = bram_base_addr;
    end else if (in_region(req.addr, clint_base_addr, clint_top_addr)) begin
      clint_sel = 1'b1;
      base_addr = clint_base_addr;
    end else if (in_region(req.addr, uart_base_addr, uart_top_addr)) begin
      uart_sel = 1'b1;
      base_addr = uart_base_addr;
    end else begin
      unmapped_sel = 1'b1;
    end
  end

  assign offset_addr = req.addr - base_addr;

  // every slave sees the rebased address, only the selected one sees valid
  always_comb begin
    bram_req = req;
    bram_req.valid = req.valid && bram_sel;
    bram_req.addr = offset_addr;
    clint_req = req;
    clint_req.valid = req.valid && clint_sel;
    clint_req.addr = offset_addr;
    uart_req = req;
    uart_req.valid = req.valid && uart_sel;
    uart_req.addr = offset_addr;
  end

  // nobody owns this address, so answer it here with zero data
  always_ff @(posedge clk) begin
    if (reset) begin
      unmapped_ready <= 1'b0;
    end else begin
      unmapped_ready <= req.valid && unmapped_sel && !unmapped_ready;
    end
  end

  always_comb begin
    if (bram_rsp.ready) begin
      rsp = bram_rsp;
    end else if (clint_rsp.ready) begin
      rsp = clint_rsp;
    end else if (uart_rsp.ready) begin
      rsp = uart_rsp;
    end else if (unmapped_ready) begin
      rsp.rdata = '0;
      rsp.ready = 1'b1;
    end else begin
      rsp = '0;
    end
  end

endmodule

/* source/bram.sv */
`timescale 1ns/10ps

module bram
#(
  parameter int bram_words = 1024
)
(
  input  logic clk,
  input  logic reset,
  input  bus_types::mem_req_t req,
  output bus_types::mem_rsp_t rsp
);
  localparam int index_bits = $clog2(bram_words);

  logic [31 : 0] mem [0 : bram_words-1];
  logic [index_bits-1 : 0] word_index;
  logic access;
  logic ready;
  logic [31 : 0] rdata;

  // the address wraps around the array
  assign word_index = index_bits'((req.addr >> 2) % bram_words);
  assign access = req.valid && !ready; // a held request is taken once

  always_ff @(posedge clk) begin
    if (access) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[word_index][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
      rdata <= mem[word_index];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  assign rsp.rdata = rdata;
  assign rsp.ready = ready;

endmodule

/* source/clint.sv */
`timescale 1ns/10ps

module clint
(
  input  logic clk,
  input  logic reset,
  input  bus_types::mem_req_t req,
  output bus_types::mem_rsp_t rsp,
  output logic msip,
  output logic mtip
);
  import configure::*;

  // the 64-bit timer registers are reached as two 32-bit bus words
  typedef union packed {
    logic [63 : 0] word;
    struct packed {
      logic [31 : 0] hi;
      logic [31 : 0] lo;
    } half;
  } timer_word_t;

  localparam logic [31 : 0] mtimecmp_hi_offset = clint_mtimecmp_offset + 32'd4;
  localparam logic [31 : 0] mtime_hi_offset = clint_mtime_offset + 32'd4;

  timer_word_t mtime;
  timer_word_t mtimecmp;
  logic msip_bit;
  logic access;
  logic write;
  logic ready;
  logic [31 : 0] read_word;
  logic [31 : 0] rdata;

  assign access = req.valid && !ready;
  assign write = access && (req.wstrb != 4'b0000);

  always_comb begin
    case (req.addr)
      clint_msip_offset:     read_word = {31'b0, msip_bit};
      clint_mtimecmp_offset: read_word = mtimecmp.half.lo;
      mtimecmp_hi_offset:    read_word = mtimecmp.half.hi;
      clint_mtime_offset:    read_word = mtime.half.lo;
      mtime_hi_offset:       read_word = mtime.half.hi;
      default:               read_word = '0;
    endcase
  end

  // mtime is read only and counts every clock
  always_ff @(posedge clk) begin
    if (reset) begin
      mtime.word <= '0;
      mtimecmp.word <= '1;
      msip_bit <= 1'b0;
      ready <= 1'b0;
    end else begin
      mtime.word <= mtime.word + 64'd1;
      ready <= access;
      if (write) begin
        case (req.addr)
          clint_msip_offset:     msip_bit <= req.wdata[0];
          clint_mtimecmp_offset: mtimecmp.half.lo <= req.wdata;
          mtimecmp_hi_offset:    mtimecmp.half.hi <= req.wdata;
          default:               ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access && !write) begin
      rdata <= read_word;
    end
  end

  assign rsp.rdata = rdata;
  assign rsp.ready = ready;
  assign msip = msip_bit;
  assign mtip = (mtime.word >= mtimecmp.word);

endmodule

/* source/uart.sv */
`timescale 1ns/10ps

module uart
#(
  parameter int clks_per_bit = 16
)
(
  input  logic clk,
  input  logic reset,
  input  bus_types::mem_req_t req,
  output bus_types::mem_rsp_t rsp,
  input  logic rx,
  output logic tx
);
  import configure::*;

  localparam int cnt_bits = $clog2(clks_per_bit);
  localparam logic [cnt_bits-1 : 0] full_bit = cnt_bits'(clks_per_bit - 1);
  localparam logic [cnt_bits-1 : 0] half_bit = cnt_bits'(clks_per_bit / 2 - 1);

  logic access;
  logic write;
  logic read;
  logic ready;
  logic [31 : 0] rdata;

  logic tx_busy;
  logic tx_start;
  logic tx_tick;
  logic [9 : 0] tx_frame;
  logic [3 : 0] tx_bit_cnt;
  logic [cnt_bits-1 : 0] tx_clk_cnt;

  logic rx_meta;
  logic rx_sync;
  logic rx_busy;
  logic rx_sample;
  logic rx_done;
  logic rx_valid;
  logic [3 : 0] rx_bit_cnt;
  logic [cnt_bits-1 : 0] rx_clk_cnt;
  logic [7 : 0] rx_shift;
  logic [7 : 0] rx_data;

  assign access = req.valid && !ready;
  assign write = access && (req.wstrb != 4'b0000);
  assign read = access && (req.wstrb == 4'b0000);

  // a write while busy is simply dropped
  assign tx_start = write && (req.addr == uart_data_offset) && !tx_busy;
  assign tx_tick = tx_busy && (tx_clk_cnt == full_bit);

  // bit 0 is the start bit and waits half a bit, the rest wait a full bit
  assign rx_sample = rx_busy && (rx_clk_cnt == ((rx_bit_cnt == 4'd0) ? half_bit : full_bit));
  assign rx_done = rx_sample && (rx_bit_cnt == 4'd9) && rx_sync; // a good stop bit

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
      tx_busy <= 1'b0;
      tx_bit_cnt <= '0;
      tx_clk_cnt <= '0;
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_busy <= 1'b0;
      rx_bit_cnt <= '0;
      rx_clk_cnt <= '0;
      rx_valid <= 1'b0;
    end else begin
      ready <= access;
      rx_meta <= rx;
      rx_sync <= rx_meta;
      if (tx_start) begin
        tx_busy <= 1'b1;
        tx_bit_cnt <= '0;
        tx_clk_cnt <= '0;
      end else if (tx_tick) begin
        tx_clk_cnt <= '0;
        tx_bit_cnt <= tx_bit_cnt + 4'd1;
        tx_busy <= (tx_bit_cnt != 4'd9);
      end else if (tx_busy) begin
        tx_clk_cnt <= tx_clk_cnt + 1'b1;
      end
      if (read && (req.addr == uart_data_offset)) begin
        rx_valid <= 1'b0;
      end
      if (!rx_busy) begin
        if (!rx_sync) begin // falling edge opens a frame
          rx_busy <= 1'b1;
          rx_bit_cnt <= '0;
          rx_clk_cnt <= '0;
        end
      end else if (rx_sample) begin
        rx_clk_cnt <= '0;
        rx_bit_cnt <= rx_bit_cnt + 4'd1;
        if ((rx_bit_cnt == 4'd0 && rx_sync) || rx_bit_cnt == 4'd9) begin
          rx_busy <= 1'b0; // frame ends, or the start bit was only a glitch
        end
        if (rx_done) begin
          rx_valid <= 1'b1;
        end
      end else begin
        rx_clk_cnt <= rx_clk_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_start) begin
      tx_frame <= {1'b1, req.wdata[7 : 0], 1'b0};
    end else if (tx_tick) begin
      tx_frame <= {1'b1, tx_frame[9 : 1]};
    end
    if (rx_sample && rx_bit_cnt != 4'd0 && rx_bit_cnt != 4'd9) begin
      rx_shift <= {rx_sync, rx_shift[7 : 1]}; // LSB arrives first
    end
    if (rx_done) begin
      rx_data <= rx_shift;
    end
    if (read) begin
      case (req.addr)
        uart_data_offset:   rdata <= {24'b0, rx_data};
        uart_status_offset: rdata <= {30'b0, rx_valid, tx_busy};
        default:            rdata <= '0;
      endcase
    end
  end

  assign tx = tx_busy ? tx_frame[0] : 1'b1;
  assign rsp.rdata = rdata;
  assign rsp.ready = ready;

endmodule

/* source/soc.sv */
`timescale 1ns/10ps

module soc
#(
  parameter int bram_words = 1024,
  parameter int clks_per_bit = 16
)
(
  input  logic clk,
  input  logic reset,
  input  bus_types::mem_req_t req,
  output bus_types::mem_rsp_t rsp,
  input  logic rx,
  output logic tx,
  output logic msip,
  output logic mtip
);
  import bus_types::*;

  mem_req_t bram_req;
  mem_req_t clint_req;
  mem_req_t uart_req;
  mem_rsp_t bram_rsp;
  mem_rsp_t clint_rsp;
  mem_rsp_t uart_rsp;

  bus_decoder decoder_comp
  (
    .clk (clk),
    .reset (reset),
    .req (req),
    .rsp (rsp),
    .bram_req (bram_req),
    .clint_req (clint_req),
    .uart_req (uart_req),
    .bram_rsp (bram_rsp),
    .clint_rsp (clint_rsp),
    .uart_rsp (uart_rsp)
  );

  bram #(
    .bram_words (bram_words)
  ) bram_comp (
    .clk (clk),
    .reset (reset),
    .req (bram_req),
    .rsp (bram_rsp)
  );

  // msip and mtip leave the chip since there is no core to take them
  clint clint_comp
  (
    .clk (clk),
    .reset (reset),
    .req (clint_req),
    .rsp (clint_rsp),
    .msip (msip),
    .mtip (mtip)
  );

  uart #(
    .clks_per_bit (clks_per_bit)
  ) uart_comp (
    .clk (clk),
    .reset (reset),
    .req (uart_req),
    .rsp (uart_rsp),
    .rx (rx),
    .tx (tx)
  );

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen
(
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* verification/soc_checker.sv */
`timescale 1ns/10ps

module soc_checker
#(
  parameter int clks_per_bit = 16
)
(
  input logic clk,
  input logic reset,
  input bus_types::mem_req_t req,
  input bus_types::mem_rsp_t rsp,
  input logic msip,
  input logic mtip,
  input logic tx
);
  import configure::*;

  logic [31 : 0] shadow [0 : 1023]; // starts unknown like the RAM
  logic [63 : 0] mtime_m;
  logic [63 : 0] mtimecmp_m;
  logic msip_m;
  logic [7 : 0] last_byte;
  logic exp_ready;
  logic [31 : 0] exp_rdata;
  logic [31 : 0] exp_mask; // only these bits of rdata are checked
  logic [31 : 0] exp_addr;
  logic started = 1'b0;
  logic ser_busy = 1'b0;
  logic [7 : 0] ser_byte;
  int ser_cnt = 0;
  int ser_bit = 0;
  int error_count = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int errors_at_start = 0;

  task automatic report_error(input string what, input logic [31 : 0] got,
                              input logic [31 : 0] exp);
    $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    error_count++;
  endtask

  task automatic check_value(input string what, input logic [31 : 0] got,
                             input logic [31 : 0] exp);
    if (got !== exp) begin
      report_error(what, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    $display("failure at %0t: %s", $time, what);
    error_count++;
  endtask

  task automatic end_test(input string name);
    if (error_count == errors_at_start) begin
      $display("test %s: passed", name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
      tests_failed++;
    end
    errors_at_start = error_count;
  endtask

  // works out what the accepted request should return and applies its write
  task automatic predict();
    logic [31 : 0] off;
    logic write;
    int idx;
    write = (req.wstrb != 4'b0000);
    exp_addr = req.addr;
    exp_rdata = '0;
    exp_mask = write ? 32'h0 : 32'hffff_ffff;
    if (req.addr >= bram_base_addr && req.addr < bram_top_addr) begin
      idx = int'(((req.addr - bram_base_addr) >> 2) % 1024);
      exp_rdata = shadow[idx];
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          shadow[idx][8*i +: 8] = req.wdata[8*i +: 8];
        end
      end
    end else if (req.addr >= clint_base_addr && req.addr < clint_top_addr) begin
      off = req.addr - clint_base_addr;
      case (off)
        clint_msip_offset: exp_rdata = {31'b0, msip_m};
        clint_mtimecmp_offset: exp_rdata = mtimecmp_m[31 : 0];
        clint_mtimecmp_offset + 32'd4: exp_rdata = mtimecmp_m[63 : 32];
        clint_mtime_offset: exp_rdata = mtime_m[31 : 0];
        clint_mtime_offset + 32'd4: exp_rdata = mtime_m[63 : 32];
        default: exp_rdata = '0;
      endcase
      if (write) begin
        if (off == clint_msip_offset) msip_m = req.wdata[0];
        if (off == clint_mtimecmp_offset) mtimecmp_m[31 : 0] = req.wdata;
        if (off == clint_mtimecmp_offset + 32'd4) mtimecmp_m[63 : 32] = req.wdata;
      end
    end else if (req.addr >= uart_base_addr && req.addr < uart_top_addr) begin
      off = req.addr - uart_base_addr;
      if (write && off == uart_data_offset) begin
        last_byte = req.wdata[7 : 0];
      end
      if (off == uart_data_offset) begin
        exp_rdata = {24'b0, last_byte};
      end else if (off == uart_status_offset) begin
        exp_mask = exp_mask & 32'hffff_fffc; // the busy flags move while the upper bits stay zero
      end
    end else begin
      exp_mask = 32'hffff_ffff; // unmapped answers zero even for writes
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      mtime_m = '0;
      mtimecmp_m = '1;
      msip_m = 1'b0;
      exp_ready = 1'b0;
      started = 1'b1;
    end else begin
      exp_ready = req.valid && !exp_ready; // a held request is answered once
      if (exp_ready) begin
        predict();
      end
      mtime_m = mtime_m + 64'd1; // after predict a read sees the old count
    end
  end

  // decodes each frame on tx and compares it with the byte last written
  always @(posedge clk) begin
    if (reset) begin
      ser_busy = 1'b0;
    end else if (!ser_busy) begin
      if (tx === 1'b0) begin
        ser_busy = 1'b1;
        ser_bit = 0;
        ser_cnt = clks_per_bit / 2; // the first sample falls in the middle of the start bit
      end
    end else begin
      ser_cnt++;
      if (ser_cnt == clks_per_bit) begin
        ser_cnt = 0;
        if (ser_bit == 0 && tx !== 1'b0) begin
          note_failure("tx start bit shorter than half a bit");
          ser_busy = 1'b0;
        end else if (ser_bit >= 1 && ser_bit <= 8) begin
          ser_byte = {tx, ser_byte[7 : 1]}; // LSB first
        end else if (ser_bit == 9) begin
          ser_busy = 1'b0;
          if (tx !== 1'b1) begin
            note_failure("tx stop bit missing");
          end else begin
            check_value("tx byte", {24'b0, ser_byte}, {24'b0, last_byte});
          end
        end
        ser_bit++;
      end
    end
  end

  always @(negedge clk) begin
    if (started && !reset) begin
      if (rsp.ready !== exp_ready) begin
        report_error("ready timing", 32'(rsp.ready), 32'(exp_ready));
      end else if (exp_ready && ((rsp.rdata & exp_mask) !== (exp_rdata & exp_mask))) begin
        report_error($sformatf("read at %h", exp_addr), rsp.rdata & exp_mask,
                     exp_rdata & exp_mask);
      end
      if (msip !== msip_m) report_error("msip port", 32'(msip), 32'(msip_m));
      if (mtip !== (mtime_m >= mtimecmp_m)) begin
        report_error("mtip port", 32'(mtip), 32'(mtime_m >= mtimecmp_m));
      end
    end
  end

endmodule

/* verification/soc_tb.sv */
`timescale 1ns/10ps

module soc_tb;
  import bus_types::*;
  import configure::*;

  localparam int uart_bit_clks = 8;

  logic clk;
  logic reset;
  mem_req_t req;
  mem_rsp_t rsp;
  logic tx;
  logic msip;
  logic mtip;
  int unsigned cycle_count = 0;
  int unsigned ready_cycle;
  logic [31 : 0] written [$];

  clock_gen clock_comp (.clk (clk), .reset (reset));

  soc #(.clks_per_bit (uart_bit_clks)) dut (
    .clk (clk), .reset (reset), .req (req), .rsp (rsp),
    .rx (tx), .tx (tx), .msip (msip), .mtip (mtip) // serial loopback
  );

  soc_checker #(.clks_per_bit (uart_bit_clks)) chk (
    .clk (clk), .reset (reset), .req (req), .rsp (rsp),
    .msip (msip), .mtip (mtip), .tx (tx)
  );

  always @(posedge clk) cycle_count <= cycle_count + 1;

  task automatic bus_access(input logic [31 : 0] addr, input logic [31 : 0] wdata,
                            input logic [3 : 0] wstrb, output logic [31 : 0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    @(posedge clk);
    #1;
    req = '{valid: 1'b1, instr: 1'b0, addr: addr, wdata: wdata, wstrb: wstrb};
    @(negedge clk);
    while (!rsp.ready && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rsp.ready) begin
      rdata = rsp.rdata;
      ready_cycle = cycle_count;
    end else begin
      chk.note_failure($sformatf("no ready for address %h", addr));
    end
    @(posedge clk);
    #1;
    req = '0;
  endtask

  task automatic bus_write(input logic [31 : 0] addr, input logic [31 : 0] wdata,
                           input logic [3 : 0] wstrb);
    logic [31 : 0] unused;
    bus_access(addr, wdata, wstrb, unused);
  endtask

  task automatic bus_read(input logic [31 : 0] addr, output logic [31 : 0] rdata);
    bus_access(addr, 32'h0, 4'h0, rdata);
  endtask

  function automatic logic is_mapped(input logic [31 : 0] addr);
    return (addr < bram_top_addr) || (addr >= clint_base_addr && addr < clint_top_addr) ||
           (addr >= uart_base_addr && addr < uart_top_addr);
  endfunction

  initial begin
    logic [31 : 0] addr;
    logic [31 : 0] data;
    logic [31 : 0] t0;
    logic [31 : 0] t1;
    logic [7 : 0] b;
    int unsigned c0;
    int unsigned off;
    int waited;
    req = '0;
    void'($urandom(32'h5524));

    waited = 0;
    while (reset && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (reset) chk.note_failure("reset never released");
    @(negedge clk);
    chk.check_value("ready after reset", 32'(rsp.ready), 32'h0);
    chk.check_value("msip after reset", 32'(msip), 32'h0);
    chk.check_value("mtip after reset", 32'(mtip), 32'h0);
    chk.check_value("tx after reset", 32'(tx), 32'h1);
    chk.end_test("reset");

    for (int i = 0; i < 200; i++) begin
      addr = (($urandom % 1024) << 2);
      bus_write(addr, $urandom, 4'(($urandom % 15) + 1));
      written.push_back(addr);
      if ($urandom % 2) begin
        bus_read(written[$urandom % written.size()], data);
      end
    end
    chk.end_test("bram");

    for (int i = 0; i < 20; i++) begin
      addr = $urandom;
      waited = 0;
      while (is_mapped(addr) && waited < 100) begin // the map covers a tiny share
        addr = $urandom;
        waited++;
      end
      if (i % 4 == 0) bus_write(addr, $urandom, 4'hf);
      else bus_read(addr, data);
      bus_read(written[0], data);
    end
    chk.end_test("unmapped");

    bus_write(clint_base_addr + clint_msip_offset, 32'h1, 4'hf);
    bus_read(clint_base_addr + clint_msip_offset, data);
    bus_write(clint_base_addr + clint_msip_offset, 32'h0, 4'hf);
    bus_read(clint_base_addr + clint_msip_offset, data);
    bus_read(clint_base_addr + clint_mtime_offset, t0);
    c0 = ready_cycle;
    repeat (5 + $urandom % 20) @(posedge clk);
    bus_read(clint_base_addr + clint_mtime_offset, t1);
    chk.check_value("mtime delta", t1 - t0, 32'(ready_cycle - c0));
    bus_read(clint_base_addr + clint_mtime_offset, t0);
    off = 20 + $urandom % 30;
    bus_write(clint_base_addr + clint_mtimecmp_offset, t0 + off, 4'hf);
    bus_write(clint_base_addr + clint_mtimecmp_offset + 32'd4, 32'h0, 4'hf);
    waited = 0;
    while (!mtip && waited < int'(off) + 10) begin
      @(negedge clk);
      waited++;
    end
    if (!mtip) chk.note_failure("mtip did not rise after mtimecmp was reached");
    bus_write(clint_base_addr + clint_mtimecmp_offset + 32'd4, 32'hffff_ffff, 4'hf);
    @(negedge clk);
    chk.check_value("mtip after mtimecmp raised", 32'(mtip), 32'h0);
    chk.end_test("clint");

    for (int i = 0; i < 10; i++) begin
      b = 8'($urandom);
      bus_write(uart_base_addr + uart_data_offset, {24'b0, b}, 4'h1);
      waited = 0;
      data = '0;
      while (!data[1] && waited < 200) begin
        bus_read(uart_base_addr + uart_status_offset, data);
        waited++;
      end
      if (!data[1]) chk.note_failure($sformatf("no byte received for %h", b));
      bus_read(uart_base_addr + uart_data_offset, data);
      chk.check_value("uart byte", {24'b0, data[7 : 0]}, {24'b0, b});
      bus_read(uart_base_addr + uart_status_offset, data);
      chk.check_value("uart status after read", {30'b0, data[1 : 0]}, 32'h0);
    end
    chk.check_value("tx idle", 32'(tx), 32'h1);
    chk.end_test("uart");

    $display("tests passed %0d failed %0d, errors %0d", chk.tests_passed, chk.tests_failed,
             chk.error_count);
    if (chk.error_count == 0 && chk.tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
source/configure.sv
source/bus_types.sv
source/bus_decoder.sv
source/bram.sv
source/clint.sv
source/uart.sv
source/soc.sv
verification/clock_gen.sv
verification/soc_checker.sv
verification/soc_tb.sv

/* Makefile */
SIM ?= verilator
TOP ?= soc_tb
LOG ?= sim.log
OBJ_DIR ?= obj_dir

SRCS := $(shell grep -v '^+' sources.f)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sources.f
	$(SIM) --binary --timing -f sources.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
